// ==== common/or_tree_pkg.sv ====
//**************************************************************************
// shared definitions for the page allocator: request sizes, fail reasons,
// the 15-bit node word, request and response records, and the per-node
// index helpers that both node engines build their masks from
//**************************************************************************
`default_nettype none

package or_tree_pkg;

    localparam int REQ_ID_W = 8;
    localparam int LEAF_N = 8;
    localparam int LEAF_W = 3;
    localparam int NODE_W = 15;

    // size value doubles as the tree level of the node
    typedef enum logic [1:0] {
        SIZE_4K  = 2'd0,
        SIZE_2K  = 2'd1,
        SIZE_1K  = 2'd2,
        SIZE_512 = 2'd3
    } size_e;

    typedef enum logic [1:0] {
        FAIL_NONE,
        FAIL_NO_SPACE,
        FAIL_BAD_FREE
    } fail_e;

    // leftmost child sits in the msb of each level
    typedef struct packed {
        logic              l4k;
        logic [1:0]        l2k;
        logic [3:0]        l1k;
        logic [LEAF_N-1:0] l512;
    } node_t;

    // node 0 is the 4K node, 1-2 the 2K nodes, 3-6 the 1K nodes, 7-14 the leaves
    typedef logic [3:0] node_idx_t;

    typedef struct packed {
        logic full_4k;
        logic full_2k;
        logic full_1k;
        logic full_512;
    } summary_t;

    typedef struct packed {
        logic [REQ_ID_W-1:0] id;
        size_e               size;
        size_e               origin_size;
    } req_info_t;

    typedef struct packed {
        logic [REQ_ID_W-1:0] id;
        logic                fail;
        fail_e               reason;
        size_e               origin_size;
        size_e               actual_size;
    } rsp_t;

    function automatic size_e node_size(node_idx_t k);
        if (k == 4'd0) return SIZE_4K;
        else if (k < 4'd3) return SIZE_2K;
        else if (k < 4'd7) return SIZE_1K;
        return SIZE_512;
    endfunction

    // leftmost leaf under node k
    function automatic logic [LEAF_W-1:0] node_first_leaf(node_idx_t k);
        logic [1:0] lvl;
        logic [3:0] pos;
        lvl = node_size(k);
        pos = k + 4'd1 - (4'd1 << lvl);
        return LEAF_W'(pos << (2'd3 - lvl));
    endfunction

    // leaves covered by node k, leaf 0 in the msb
    function automatic logic [LEAF_N-1:0] node_leaves(node_idx_t k);
        logic [LEAF_N-1:0] top;
        top = ~({LEAF_N{1'b1}} >> (4'd8 >> node_size(k)));
        return top >> node_first_leaf(k);
    endfunction

endpackage

`default_nettype wire

// ==== logic/tree_ram.sv ====
//**************************************************************************
// node word store, one word per tree: two registered read ports and one
// write port. a word never written since reset reads back as zero
//**************************************************************************
`default_nettype none

module tree_ram #(
    parameter int TREE_IDX_W = 12
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  wr_en,
    input  wire logic [TREE_IDX_W-1:0] wr_addr,
    input  wire or_tree_pkg::node_t    wr_data,
    input  wire logic [TREE_IDX_W-1:0] rd_addr_a,
    input  wire logic [TREE_IDX_W-1:0] rd_addr_b,
    output or_tree_pkg::node_t         rd_data_a,
    output or_tree_pkg::node_t         rd_data_b
);
    import or_tree_pkg::*;

    localparam int DEPTH = 2 ** TREE_IDX_W;

    node_t            mem [DEPTH];
    logic [DEPTH-1:0] written;
    node_t            q_a;
    node_t            q_b;
    logic             hit_a;
    logic             hit_b;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        q_a <= mem[rd_addr_a];
        q_b <= mem[rd_addr_b];
    end

    // per-entry flags stand in for clearing the whole array
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            written <= '0;
            hit_a <= 1'b0;
            hit_b <= 1'b0;
        end else begin
            if (wr_en) begin
                written[wr_addr] <= 1'b1;
            end
            hit_a <= written[rd_addr_a];
            hit_b <= written[rd_addr_b];
        end
    end

    assign rd_data_a = hit_a ? q_a : '0;
    assign rd_data_b = hit_b ? q_b : '0;

endmodule

`default_nettype wire

// ==== or_tree/alloc_search.sv ====
//**************************************************************************
// alloc node engine: picks the leftmost clear node at the requested level
// of a node word and returns the word with that node marked in use
//**************************************************************************
`default_nettype none

module alloc_search (
    input  wire or_tree_pkg::size_e          size,
    input  wire or_tree_pkg::node_t          node,
    output logic                             found,
    output logic [or_tree_pkg::LEAF_W-1:0]   leaf,
    output or_tree_pkg::node_t               new_node
);
    import or_tree_pkg::*;

    logic [NODE_W-1:0] old_bits;
    logic [NODE_W-1:0] new_bits;
    node_idx_t         pick;
    logic [LEAF_N-1:0] pick_leaves;

    // node k lives in bit NODE_W-1-k
    assign old_bits = node;

    // walk right to left so the leftmost candidate is the last one kept
    always_comb begin
        found = 1'b0;
        pick = '0;
        for (int k = NODE_W - 1; k >= 0; k--) begin
            if (node_size(node_idx_t'(k)) == size && !old_bits[NODE_W-1-k]) begin
                found = 1'b1;
                pick = node_idx_t'(k);
            end
        end
    end

    assign pick_leaves = node_leaves(pick);
    assign leaf = node_first_leaf(pick);

    // nodes whose leaves overlap the pick are the pick itself, its
    // ancestors and its descendants, and all of them become used
    always_comb begin
        for (int k = 0; k < NODE_W; k++) begin
            new_bits[NODE_W-1-k] = old_bits[NODE_W-1-k] |
                                   (|(node_leaves(node_idx_t'(k)) & pick_leaves));
        end
    end

    assign new_node = found ? node_t'(new_bits) : node;

endmodule

`default_nettype wire

// ==== or_tree/free_check.sv ====
//**************************************************************************
// free node engine: checks that a page is aligned to its size and that
// every leaf under the node is in use, then clears that node and rebuilds
// its ancestors from the remaining leaves so freed space merges again
//**************************************************************************
`default_nettype none

module free_check (
    input  wire or_tree_pkg::size_e          size,
    input  wire logic [or_tree_pkg::LEAF_W-1:0] leaf,
    input  wire or_tree_pkg::node_t          node,
    output logic                             ok,
    output or_tree_pkg::node_t               new_node
);
    import or_tree_pkg::*;

    logic [1:0]        lvl;
    node_idx_t         target;
    logic [LEAF_N-1:0] span;
    logic [LEAF_N-1:0] kept_leaves;
    logic [NODE_W-1:0] old_bits;
    logic [NODE_W-1:0] new_bits;

    assign lvl = size;
    assign old_bits = node;

    // node at the requested level that holds the leaf
    assign target = node_idx_t'((4'd1 << lvl) - 4'd1 + {1'b0, leaf >> (2'd3 - lvl)});
    assign span = node_leaves(target);

    // misaligned when the leaf is not the node's first leaf
    assign ok = (node_first_leaf(target) == leaf) && ((node.l512 & span) == span);

    assign kept_leaves = node.l512 & ~span;

    // every node above a set leaf is set, so a node touching the freed range
    // is simply the OR of what stays in use beneath it
    always_comb begin
        for (int k = 0; k < NODE_W; k++) begin
            if (|(node_leaves(node_idx_t'(k)) & span)) begin
                new_bits[NODE_W-1-k] = |(node_leaves(node_idx_t'(k)) & kept_leaves);
            end else begin
                new_bits[NODE_W-1-k] = old_bits[NODE_W-1-k];
            end
        end
    end

    assign new_node = ok ? node_t'(new_bits) : node;

endmodule

`default_nettype wire

// ==== or_tree/or_tree_ctrl.sv ====
//**************************************************************************
// pipeline control for the allocator. stage 1 meets the RAM read data,
// stage 2 holds the engine decisions and drives the write-back, and the
// responses and table update are registered out at the third edge
//**************************************************************************
`default_nettype none

module or_tree_ctrl #(
    parameter int TREE_IDX_W = 12
) (
    input  wire logic                                      clk,
    input  wire logic                                      rst_n,
    input  wire logic                                      alloc_valid,
    input  wire logic [TREE_IDX_W-1:0]                     alloc_tree_index,
    input  wire or_tree_pkg::req_info_t                    alloc_info,
    input  wire logic                                      free_valid,
    input  wire logic [TREE_IDX_W+or_tree_pkg::LEAF_W-1:0] free_page_index,
    input  wire or_tree_pkg::req_info_t                    free_info,
    output logic                                           alloc_rsp_valid,
    output or_tree_pkg::rsp_t                              alloc_rsp,
    output logic [TREE_IDX_W+or_tree_pkg::LEAF_W-1:0]      alloc_rsp_page_index,
    output logic                                           free_rsp_valid,
    output or_tree_pkg::rsp_t                              free_rsp,
    output logic                                           at_update_en,
    output logic [TREE_IDX_W/2-1:0]                        at_update_row,
    output logic [TREE_IDX_W/2-1:0]                        at_update_column,
    output or_tree_pkg::summary_t                          at_update_summary,
    output logic [TREE_IDX_W-1:0]                          rd_addr_a,
    output logic [TREE_IDX_W-1:0]                          rd_addr_b,
    output logic                                           wr_en,
    output logic [TREE_IDX_W-1:0]                          wr_addr,
    output or_tree_pkg::node_t                             wr_data,
    output or_tree_pkg::size_e                             alloc_size,
    output or_tree_pkg::size_e                             free_size,
    output logic [or_tree_pkg::LEAF_W-1:0]                 free_leaf,
    input  wire logic                                      found,
    input  wire logic [or_tree_pkg::LEAF_W-1:0]            alloc_leaf,
    input  wire or_tree_pkg::node_t                        alloc_node,
    input  wire logic                                      free_ok,
    input  wire or_tree_pkg::node_t                        free_node
);
    import or_tree_pkg::*;

    localparam int PAGE_W = TREE_IDX_W + LEAF_W;
    localparam int HALF_W = TREE_IDX_W / 2;

    logic                  req_valid;
    logic [TREE_IDX_W-1:0] req_tree;
    logic                  s1_alloc;
    logic                  s1_free;
    logic [TREE_IDX_W-1:0] s1_tree;
    logic [LEAF_W-1:0]     s1_leaf;
    req_info_t             s1_info;
    logic                  s2_alloc;
    logic                  s2_free;
    logic                  s2_ok;
    logic [TREE_IDX_W-1:0] s2_tree;
    logic [LEAF_W-1:0]     s2_leaf;
    req_info_t             s2_info;
    node_t                 s2_node;
    rsp_t                  rsp_d;

    // both channels share one pipeline since they never fire together
    assign req_valid = alloc_valid | free_valid;
    assign req_tree = alloc_valid ? alloc_tree_index : free_page_index[PAGE_W-1:LEAF_W];

    assign rd_addr_a = alloc_tree_index;
    assign rd_addr_b = free_page_index[PAGE_W-1:LEAF_W];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_alloc <= 1'b0;
            s1_free <= 1'b0;
            s2_alloc <= 1'b0;
            s2_free <= 1'b0;
            s2_ok <= 1'b0;
        end else begin
            s1_alloc <= alloc_valid;
            s1_free <= free_valid;
            s2_alloc <= s1_alloc;
            s2_free <= s1_free;
            s2_ok <= s1_alloc ? found : free_ok;
        end
    end

    always_ff @(posedge clk) begin
        s1_tree <= req_tree;
        s1_leaf <= free_page_index[LEAF_W-1:0];
        s1_info <= alloc_valid ? alloc_info : free_info;
        s2_tree <= s1_tree;
        s2_leaf <= alloc_leaf;
        s2_info <= s1_info;
        s2_node <= s1_alloc ? alloc_node : free_node;
    end

    // engines see stage 1 alongside the RAM read data
    assign alloc_size = s1_info.size;
    assign free_size = s1_info.size;
    assign free_leaf = s1_leaf;

    // only a successful request changes the stored word
    assign wr_en = (s2_alloc | s2_free) & s2_ok;
    assign wr_addr = s2_tree;
    assign wr_data = s2_node;

    always_comb begin
        rsp_d.id = s2_info.id;
        rsp_d.fail = !s2_ok;
        rsp_d.origin_size = s2_info.origin_size;
        rsp_d.actual_size = s2_ok ? s2_info.size : SIZE_4K;
        if (s2_ok) rsp_d.reason = FAIL_NONE;
        else if (s2_alloc) rsp_d.reason = FAIL_NO_SPACE;
        else rsp_d.reason = FAIL_BAD_FREE;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alloc_rsp_valid <= 1'b0;
            free_rsp_valid <= 1'b0;
            at_update_en <= 1'b0;
        end else begin
            alloc_rsp_valid <= s2_alloc;
            free_rsp_valid <= s2_free;
            // a failed alloc still reports so the table can drop its mask
            at_update_en <= s2_alloc | (s2_free & s2_ok);
        end
    end

    always_ff @(posedge clk) begin
        if (s2_alloc) begin
            alloc_rsp <= rsp_d;
            alloc_rsp_page_index <= s2_ok ? {s2_tree, s2_leaf} : '0;
        end
        if (s2_free) begin
            free_rsp <= rsp_d;
        end
        at_update_row <= s2_tree[TREE_IDX_W-1:HALF_W];
        at_update_column <= s2_tree[HALF_W-1:0];
        at_update_summary <= '{
            full_4k:  s2_node.l4k,
            full_2k:  &s2_node.l2k,
            full_1k:  &s2_node.l1k,
            full_512: &s2_node.l512
        };
    end

    a_one_request: assert property (@(posedge clk) disable iff (!rst_n)
        !(alloc_valid && free_valid));

    // a tree in flight has not been written back yet, so a new read would be stale
    a_no_tree_hazard: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> !((s1_alloc || s1_free) && s1_tree == req_tree) &&
                      !((s2_alloc || s2_free) && s2_tree == req_tree));

endmodule

`default_nettype wire

// ==== or_tree/or_tree.sv ====
//**************************************************************************
// page allocator top level: joins the pipeline controller, the alloc and
// free node engines and the node word RAM. requests are valid-only and
// every response and table update follows three cycles later
//**************************************************************************
`default_nettype none

module or_tree #(
    parameter int TREE_IDX_W = 12
) (
    input  wire logic                                      clk,
    input  wire logic                                      rst_n,
    input  wire logic                                      alloc_valid,
    input  wire logic [TREE_IDX_W-1:0]                     alloc_tree_index,
    input  wire or_tree_pkg::req_info_t                    alloc_info,
    input  wire logic                                      free_valid,
    input  wire logic [TREE_IDX_W+or_tree_pkg::LEAF_W-1:0] free_page_index,
    input  wire or_tree_pkg::req_info_t                    free_info,
    output logic                                           alloc_rsp_valid,
    output or_tree_pkg::rsp_t                              alloc_rsp,
    output logic [TREE_IDX_W+or_tree_pkg::LEAF_W-1:0]      alloc_rsp_page_index,
    output logic                                           free_rsp_valid,
    output or_tree_pkg::rsp_t                              free_rsp,
    output logic                                           at_update_en,
    output logic [TREE_IDX_W/2-1:0]                        at_update_row,
    output logic [TREE_IDX_W/2-1:0]                        at_update_column,
    output or_tree_pkg::summary_t                          at_update_summary
);
    import or_tree_pkg::*;

    logic [TREE_IDX_W-1:0] rd_addr_a;
    logic [TREE_IDX_W-1:0] rd_addr_b;
    node_t                 rd_data_a;
    node_t                 rd_data_b;
    logic                  wr_en;
    logic [TREE_IDX_W-1:0] wr_addr;
    node_t                 wr_data;
    size_e                 alloc_size;
    size_e                 free_size;
    logic [LEAF_W-1:0]     free_leaf;
    logic                  found;
    logic [LEAF_W-1:0]     alloc_leaf;
    node_t                 alloc_node;
    logic                  free_ok;
    node_t                 free_node;

    or_tree_ctrl #(
        .TREE_IDX_W(TREE_IDX_W)
    ) ctrl_i (
        .clk                 (clk),
        .rst_n               (rst_n),
        .alloc_valid         (alloc_valid),
        .alloc_tree_index    (alloc_tree_index),
        .alloc_info          (alloc_info),
        .free_valid          (free_valid),
        .free_page_index     (free_page_index),
        .free_info           (free_info),
        .alloc_rsp_valid     (alloc_rsp_valid),
        .alloc_rsp           (alloc_rsp),
        .alloc_rsp_page_index(alloc_rsp_page_index),
        .free_rsp_valid      (free_rsp_valid),
        .free_rsp            (free_rsp),
        .at_update_en        (at_update_en),
        .at_update_row       (at_update_row),
        .at_update_column    (at_update_column),
        .at_update_summary   (at_update_summary),
        .rd_addr_a           (rd_addr_a),
        .rd_addr_b           (rd_addr_b),
        .wr_en               (wr_en),
        .wr_addr             (wr_addr),
        .wr_data             (wr_data),
        .alloc_size          (alloc_size),
        .free_size           (free_size),
        .free_leaf           (free_leaf),
        .found               (found),
        .alloc_leaf          (alloc_leaf),
        .alloc_node          (alloc_node),
        .free_ok             (free_ok),
        .free_node           (free_node)
    );

    alloc_search alloc_i (
        .size    (alloc_size),
        .node    (rd_data_a),
        .found   (found),
        .leaf    (alloc_leaf),
        .new_node(alloc_node)
    );

    free_check free_i (
        .size    (free_size),
        .leaf    (free_leaf),
        .node    (rd_data_b),
        .ok      (free_ok),
        .new_node(free_node)
    );

    tree_ram #(
        .TREE_IDX_W(TREE_IDX_W)
    ) ram_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_addr_a(rd_addr_a),
        .rd_addr_b(rd_addr_b),
        .rd_data_a(rd_data_a),
        .rd_data_b(rd_data_b)
    );

endmodule

`default_nettype wire

// ==== bench/or_tree_model.svh ====
//**************************************************************************
// reference model for the allocator testbench: keeps the used leaves of
// every tree, derives node words from them and queues the expected
// response and table update of each request at the time it is issued
//**************************************************************************
`ifndef OR_TREE_MODEL_SVH
`define OR_TREE_MODEL_SVH

typedef struct {
    int unsigned         due;
    logic                is_alloc;
    rsp_t                rsp;
    logic [PAGE_W-1:0]   page;
    logic                upd;
    logic [HALF_W-1:0]   row;
    logic [HALF_W-1:0]   col;
    summary_t            summary;
} expect_t;

// leaf 0 sits in the msb, as in the l512 field
logic [7:0] used_leaves [TREE_N];
expect_t    expected [$];

// leaves covered by node pos of level lvl
function automatic logic [7:0] leaf_span(int lvl, int pos);
    int width;
    width = 8 >> lvl;
    return 8'(((1 << width) - 1) << (8 - width * (pos + 1)));
endfunction

// a node counts as used when any leaf under it is used
function automatic node_t word_of(logic [7:0] leaves);
    node_t w;
    int    j;
    w.l512 = leaves;
    for (j = 0; j < 4; j++) begin
        w.l1k[3-j] = |(leaves & leaf_span(2, j));
    end
    for (j = 0; j < 2; j++) begin
        w.l2k[1-j] = |(leaves & leaf_span(1, j));
    end
    w.l4k = |leaves;
    return w;
endfunction

function automatic summary_t level_full(node_t w);
    summary_t s;
    s.full_4k = w.l4k;
    s.full_2k = &w.l2k;
    s.full_1k = &w.l1k;
    s.full_512 = &w.l512;
    return s;
endfunction

task automatic predict_alloc(input int tree, input int lvl, input logic [REQ_ID_W-1:0] id,
                             input size_e osz, input int unsigned due,
                             output logic found, output int leaf);
    expect_t    e;
    logic [7:0] m;
    int         pos;
    found = 1'b0;
    leaf = 0;
    m = '0;
    // scan right to left so the leftmost free node wins
    for (pos = (1 << lvl) - 1; pos >= 0; pos--) begin
        if ((used_leaves[tree] & leaf_span(lvl, pos)) == 8'h00) begin
            found = 1'b1;
            leaf = pos * (8 >> lvl);
            m = leaf_span(lvl, pos);
        end
    end
    used_leaves[tree] = used_leaves[tree] | m;
    e.due = due;
    e.is_alloc = 1'b1;
    e.rsp.id = id;
    e.rsp.fail = !found;
    e.rsp.reason = found ? FAIL_NONE : FAIL_NO_SPACE;
    e.rsp.origin_size = osz;
    e.rsp.actual_size = found ? size_e'(lvl[1:0]) : SIZE_4K;
    e.page = found ? PAGE_W'(tree * LEAF_N + leaf) : '0;
    e.upd = 1'b1;
    e.row = HALF_W'(tree >> HALF_W);
    e.col = HALF_W'(tree);
    e.summary = level_full(word_of(used_leaves[tree]));
    expected.push_back(e);
endtask

task automatic apply_free(input int tree, input int leaf, input int lvl,
                          input logic [REQ_ID_W-1:0] id, input size_e osz,
                          input int unsigned due);
    expect_t    e;
    logic [7:0] m;
    logic       ok;
    int         width;
    width = 8 >> lvl;
    m = leaf_span(lvl, leaf / width);
    ok = (leaf % width == 0) && ((used_leaves[tree] & m) == m);
    if (ok) begin
        used_leaves[tree] = used_leaves[tree] & ~m;
    end
    e.due = due;
    e.is_alloc = 1'b0;
    e.rsp.id = id;
    e.rsp.fail = !ok;
    e.rsp.reason = ok ? FAIL_NONE : FAIL_BAD_FREE;
    e.rsp.origin_size = osz;
    e.rsp.actual_size = ok ? size_e'(lvl[1:0]) : SIZE_4K;
    e.page = '0;
    e.upd = ok;
    e.row = HALF_W'(tree >> HALF_W);
    e.col = HALF_W'(tree);
    e.summary = level_full(word_of(used_leaves[tree]));
    expected.push_back(e);
endtask

`endif

// ==== bench/or_tree_tb.sv ====
//**************************************************************************
// testbench for the page allocator: seeded random alloc and free traffic
// on 16 trees, each response and table update checked against the model
// three cycles after its request
//**************************************************************************
`default_nettype none

module or_tree_tb;
    import or_tree_pkg::*;

    localparam int TREE_IDX_W = 4;
    localparam int TREE_N = 2 ** TREE_IDX_W;
    localparam int PAGE_W = TREE_IDX_W + LEAF_W;
    localparam int HALF_W = TREE_IDX_W / 2;
    localparam int PERIOD = 10;
    localparam int RESET_CYCLES = 10;
    localparam int DIRECTED = 4;
    localparam int SLOTS = 2000;
    localparam int LATENCY = 3;
    localparam int MARGIN = 100;

    typedef struct {
        int tree;
        int leaf;
        int lvl;
    } block_t;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  alloc_valid;
    logic [TREE_IDX_W-1:0] alloc_tree_index;
    req_info_t             alloc_info;
    logic                  free_valid;
    logic [PAGE_W-1:0]     free_page_index;
    req_info_t             free_info;
    logic                  alloc_rsp_valid;
    rsp_t                  alloc_rsp;
    logic [PAGE_W-1:0]     alloc_rsp_page_index;
    logic                  free_rsp_valid;
    rsp_t                  free_rsp;
    logic                  at_update_en;
    logic [HALF_W-1:0]     at_update_row;
    logic [HALF_W-1:0]     at_update_column;
    summary_t              at_update_summary;

    int unsigned         cyc;
    int                  last1;
    int                  last2;
    logic [REQ_ID_W-1:0] next_id;
    int                  checks;
    int                  value_errors;
    int                  timing_errors;
    block_t              blocks [$];

    `include "or_tree_model.svh"

    or_tree #(
        .TREE_IDX_W(TREE_IDX_W)
    ) or_tree_i (
        .clk                 (clk),
        .rst_n               (rst_n),
        .alloc_valid         (alloc_valid),
        .alloc_tree_index    (alloc_tree_index),
        .alloc_info          (alloc_info),
        .free_valid          (free_valid),
        .free_page_index     (free_page_index),
        .free_info           (free_info),
        .alloc_rsp_valid     (alloc_rsp_valid),
        .alloc_rsp           (alloc_rsp),
        .alloc_rsp_page_index(alloc_rsp_page_index),
        .free_rsp_valid      (free_rsp_valid),
        .free_rsp            (free_rsp),
        .at_update_en        (at_update_en),
        .at_update_row       (at_update_row),
        .at_update_column    (at_update_column),
        .at_update_summary   (at_update_summary)
    );

    always #(PERIOD / 2) clk = ~clk;

    // read at a rising edge this still holds the count of earlier edges
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // a new request must avoid the trees of the two requests before it
    task automatic pick_tree(output int t);
        t = $urandom_range(0, TREE_N - 1);
        while (t == last1 || t == last2) begin
            t = $urandom_range(0, TREE_N - 1);
        end
    endtask

    task automatic send_alloc(input int t, input int lvl);
        req_info_t info;
        logic      found;
        int        leaf;
        block_t    b;
        info.id = next_id;
        info.size = size_e'(lvl[1:0]);
        info.origin_size = size_e'($urandom_range(0, 3));
        @(posedge clk);
        alloc_valid <= 1'b1;
        free_valid <= 1'b0;
        alloc_tree_index <= TREE_IDX_W'(t);
        alloc_info <= info;
        predict_alloc(t, lvl, next_id, info.origin_size, cyc + 1 + LATENCY, found, leaf);
        if (found) begin
            b.tree = t;
            b.leaf = leaf;
            b.lvl = lvl;
            blocks.push_back(b);
        end
        next_id = next_id + 1'b1;
        last2 = last1;
        last1 = t;
    endtask

    task automatic post_free(input int t, input int leaf, input int lvl);
        req_info_t info;
        info.id = next_id;
        info.size = size_e'(lvl[1:0]);
        info.origin_size = size_e'($urandom_range(0, 3));
        @(posedge clk);
        alloc_valid <= 1'b0;
        free_valid <= 1'b1;
        free_page_index <= PAGE_W'(t * LEAF_N + leaf);
        free_info <= info;
        apply_free(t, leaf, lvl, next_id, info.origin_size, cyc + 1 + LATENCY);
        next_id = next_id + 1'b1;
        last2 = last1;
        last1 = t;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        alloc_valid <= 1'b0;
        free_valid <= 1'b0;
    endtask

    // most frees return a block the model handed out, with its own size
    task automatic take_block(output logic hit, output int t, output int leaf, output int lvl);
        int start;
        int i;
        int j;
        hit = 1'b0;
        t = 0;
        leaf = 0;
        lvl = 0;
        if (blocks.size() != 0 && $urandom_range(0, 99) < 80) begin
            start = $urandom_range(0, blocks.size() - 1);
            for (i = 0; i < blocks.size() && !hit; i++) begin
                j = (start + i) % blocks.size();
                if (blocks[j].tree != last1 && blocks[j].tree != last2) begin
                    hit = 1'b1;
                    t = blocks[j].tree;
                    leaf = blocks[j].leaf;
                    lvl = blocks[j].lvl;
                    blocks.delete(j);
                end
            end
        end
    endtask

    task automatic compare_outputs();
        expect_t e;
        if (expected.size() != 0 && expected[0].due == cyc) begin
            e = expected.pop_front();
            checks++;
            if (e.is_alloc) begin
                assert (alloc_rsp_valid === 1'b1 && free_rsp_valid === 1'b0) else begin
                    $display("error %0t: alloc id %0d response valid missing", $time, e.rsp.id);
                    timing_errors++;
                end
                assert (alloc_rsp === e.rsp && alloc_rsp_page_index === e.page) else begin
                    $display("error %0t: alloc id %0d got rsp %h page %0d, expected rsp %h page %0d",
                             $time, e.rsp.id, alloc_rsp, alloc_rsp_page_index, e.rsp, e.page);
                    value_errors++;
                end
            end else begin
                assert (free_rsp_valid === 1'b1 && alloc_rsp_valid === 1'b0) else begin
                    $display("error %0t: free id %0d response valid missing", $time, e.rsp.id);
                    timing_errors++;
                end
                assert (free_rsp === e.rsp) else begin
                    $display("error %0t: free id %0d got rsp %h, expected %h",
                             $time, e.rsp.id, free_rsp, e.rsp);
                    value_errors++;
                end
            end
            assert (at_update_en === e.upd) else begin
                $display("error %0t: id %0d table update enable %b, expected %b",
                         $time, e.rsp.id, at_update_en, e.upd);
                timing_errors++;
            end
            if (e.upd) begin
                assert (at_update_row === e.row && at_update_column === e.col &&
                        at_update_summary === e.summary) else begin
                    $display("error %0t: id %0d update row %0d col %0d sum %b, expected %0d %0d %b",
                             $time, e.rsp.id, at_update_row, at_update_column,
                             at_update_summary, e.row, e.col, e.summary);
                    value_errors++;
                end
            end
        end else begin
            assert (alloc_rsp_valid === 1'b0 && free_rsp_valid === 1'b0 &&
                    at_update_en === 1'b0) else begin
                $display("error %0t: response or table update with no request due", $time);
                timing_errors++;
            end
        end
    endtask

    // outputs settle after the rising edge, so they are read on the falling one
    always @(negedge clk) begin
        compare_outputs();
    end

    initial begin
        #((RESET_CYCLES + DIRECTED + SLOTS + MARGIN) * PERIOD);
        $display("watchdog expired with %0d responses still outstanding", expected.size());
        $display("Regression failed");
        $finish;
    end

    initial begin
        int   s;
        int   r;
        int   t;
        int   leaf;
        int   lvl;
        logic hit;
        void'($urandom(92));
        rst_n = 1'b0;
        alloc_valid = 1'b0;
        alloc_tree_index = '0;
        alloc_info = '0;
        free_valid = 1'b0;
        free_page_index = '0;
        free_info = '0;
        cyc = 0;
        last1 = -1;
        last2 = -1;
        next_id = '0;
        checks = 0;
        value_errors = 0;
        timing_errors = 0;
        for (t = 0; t < TREE_N; t++) begin
            used_leaves[t] = 8'h00;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        idle_cycle();

        // first block of every size in a fresh tree lands on leaf 0
        for (lvl = 0; lvl < DIRECTED; lvl++) begin
            send_alloc(lvl, lvl);
        end

        for (s = 0; s < SLOTS; s++) begin
            r = $urandom_range(0, 99);
            if (r < 45) begin
                pick_tree(t);
                send_alloc(t, $urandom_range(0, 3));
            end else if (r < 80) begin
                take_block(hit, t, leaf, lvl);
                if (!hit) begin
                    pick_tree(t);
                    leaf = $urandom_range(0, 7);
                    lvl = $urandom_range(0, 3);
                end
                post_free(t, leaf, lvl);
            end else begin
                idle_cycle();
            end
        end
        idle_cycle();

        while (expected.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);

        $display("checks %0d, value errors %0d, timing errors %0d",
                 checks, value_errors, timing_errors);
        if (value_errors + timing_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+bench
common/or_tree_pkg.sv
logic/tree_ram.sv
or_tree/alloc_search.sv
or_tree/free_check.sv
or_tree/or_tree_ctrl.sv
or_tree/or_tree.sv
bench/or_tree_tb.sv

// ==== Makefile ====
# Verilator build and run of the page allocator testbench
# a run passes only when the log holds the pass line

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module or_tree_tb -f compile.f
	./obj_dir/Vor_tree_tb | tee sim.log
	grep -qx "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
